//--- compile.f
logic/reg_map_pkg.sv
logic/cfg_cmd_pkg.sv
logic/cmd_queue.sv
logic/cdc_handshake.sv
logic/reg_bank.sv
logic/cfg_bridge_top.sv
sim/cfg_bridge_tb.sv

//--- logic/cdc_handshake.sv
module cdc_handshake (
  input  logic                  clk_src_i,
  input  logic                  clk_dst_i,
  input  logic                  reset_i,
  // source side, clk_src_i
  input  logic                  src_valid_i,
  input  cfg_cmd_pkg::cfg_cmd_t src_cmd_i,
  output logic                  src_ready_o,
  // destination side, clk_dst_i
  output logic                  dst_valid_o,
  output cfg_cmd_pkg::cfg_cmd_t dst_cmd_o
);
  import cfg_cmd_pkg::*;

  // two-phase toggle handshake, one command in flight at a time
  //
  // source: latch the command into the hold register and flip req
  // destination: once req differs from ack, use the held word and copy req into ack
  // source: ready again once ack has come back and matches req
  //
  // the hold register only changes on acceptance, and acceptance needs
  // the returned ack, so the word is stable while the destination uses it

  // source domain state
  cfg_cmd_t hold_q;
  logic     src_req_q;
  logic     ack_meta_q;
  logic     src_ack_q2;
  logic     src_accept;

  // destination domain state
  logic     req_meta_q;
  logic     dst_req_q2;
  logic     dst_ack_q;

  // nothing in flight when our req matches the returned ack
  assign src_ready_o = (src_req_q == src_ack_q2);
  assign src_accept  = src_valid_i && src_ready_o;

  // hold register for the command being crossed
  always_ff @(posedge clk_src_i) begin
    if (src_accept) begin
      hold_q <= src_cmd_i;
    end
  end

  // req flips on the same edge the command is latched
  always_ff @(posedge clk_src_i) begin
    if (reset_i) begin
      src_req_q <= 1'b0;
    end else if (src_accept) begin
      src_req_q <= ~src_req_q;
    end
  end

  // ack back into the source domain, two flops
  always_ff @(posedge clk_src_i) begin
    if (reset_i) begin
      ack_meta_q <= 1'b0;
      src_ack_q2 <= 1'b0;
    end else begin
      ack_meta_q <= dst_ack_q;
      src_ack_q2 <= ack_meta_q;
    end
  end

  // req into the destination domain, two flops, then the ack state flop
  always_ff @(posedge clk_dst_i) begin
    if (reset_i) begin
      req_meta_q <= 1'b0;
      dst_req_q2 <= 1'b0;
      dst_ack_q  <= 1'b0;
    end else begin
      req_meta_q <= src_req_q;
      dst_req_q2 <= req_meta_q;
      // ack follows req one cycle behind
      dst_ack_q  <= dst_req_q2;
    end
  end

  // a new req is pending for exactly one destination cycle
  assign dst_valid_o = (dst_req_q2 != dst_ack_q);

  // the held word itself, settled long before dst_valid_o rises
  assign dst_cmd_o = hold_q;

endmodule

//--- logic/cfg_bridge_top.sv
module cfg_bridge_top #(
  // must be a power of two
  parameter int QueueDepth = 4,
  // at most 2**AddrWidth
  parameter int NumRegs    = 12
) (
  input  logic                                          clk_src_i,
  input  logic                                          clk_dst_i,
  input  logic                                          reset_i,
  // source controller side, clk_src_i
  input  logic                                          cmd_valid_i,
  input  cfg_cmd_pkg::cfg_cmd_t                         cmd_i,
  output logic                                          cmd_ready_o,
  // register bank side, clk_dst_i
  output logic [NumRegs-1:0][reg_map_pkg::RegWidth-1:0] regs_o,
  output logic                                          upd_valid_o,
  output reg_map_pkg::reg_update_t                      upd_o
);
  import cfg_cmd_pkg::*;

  // queue head towards the crossing
  cfg_cmd_t q_cmd;
  logic     q_valid;
  logic     q_ready;

  // command delivered in the destination domain
  cfg_cmd_t xfer_cmd;
  logic     xfer_valid;

  // source side buffering, back-pressure through cmd_ready_o
  cmd_queue #(
    .QueueDepth (QueueDepth)
  ) u_cmd_queue (
    .clk_src_i    (clk_src_i),
    .reset_i      (reset_i),
    .push_valid_i (cmd_valid_i),
    .push_cmd_i   (cmd_i),
    .push_ready_o (cmd_ready_o),
    .pop_ready_i  (q_ready),
    .pop_valid_o  (q_valid),
    .pop_cmd_o    (q_cmd)
  );

  // one command at a time across the clock boundary
  cdc_handshake u_cdc_handshake (
    .clk_src_i   (clk_src_i),
    .clk_dst_i   (clk_dst_i),
    .reset_i     (reset_i),
    .src_valid_i (q_valid),
    .src_cmd_i   (q_cmd),
    .src_ready_o (q_ready),
    .dst_valid_o (xfer_valid),
    .dst_cmd_o   (xfer_cmd)
  );

  // destination registers and update reports
  reg_bank #(
    .NumRegs (NumRegs)
  ) u_reg_bank (
    .clk_dst_i   (clk_dst_i),
    .reset_i     (reset_i),
    .cmd_valid_i (xfer_valid),
    .cmd_i       (xfer_cmd),
    .regs_o      (regs_o),
    .upd_valid_o (upd_valid_o),
    .upd_o       (upd_o)
  );

endmodule

//--- logic/cfg_cmd_pkg.sv
package cfg_cmd_pkg;

  // register operations carried by one command
  typedef enum logic [1:0] {
    // replace the register contents with the data
    op_write      = 2'd0,
    // or the data into the register
    op_set_bits   = 2'd1,
    // clear every bit that is set in the data
    op_clear_bits = 2'd2
  } cfg_op_e;

  // one register command
  // this is the word that sits in the queue and crosses the clock boundary
  // widths follow the register map so both domains agree on the layout
  typedef struct packed {
    cfg_op_e                          op;
    logic [reg_map_pkg::AddrWidth-1:0] addr;
    logic [reg_map_pkg::RegWidth-1:0]  data;
  } cfg_cmd_t;

endpackage

//--- logic/cmd_queue.sv
module cmd_queue #(
  parameter int QueueDepth = 4
) (
  input  logic                  clk_src_i,
  input  logic                  reset_i,
  // push side, facing the source controller
  input  logic                  push_valid_i,
  input  cfg_cmd_pkg::cfg_cmd_t push_cmd_i,
  output logic                  push_ready_o,
  // pop side, facing the crossing
  input  logic                  pop_ready_i,
  output logic                  pop_valid_o,
  output cfg_cmd_pkg::cfg_cmd_t pop_cmd_o
);
  import cfg_cmd_pkg::*;

  // pointer width, kept at one bit for a single entry queue
  localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  // occupancy needs to reach QueueDepth itself
  localparam int CntWidth = $clog2(QueueDepth + 1);
  localparam logic [PtrWidth-1:0] LastSlot = PtrWidth'(QueueDepth - 1);
  localparam logic [CntWidth-1:0] FullCount = CntWidth'(QueueDepth);

  cfg_cmd_t            mem_q [QueueDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  // full and empty both come straight from the occupancy count
  assign push_ready_o = (count_q != FullCount);
  assign pop_valid_o  = (count_q != '0);

  // oldest entry is always presented at the read pointer
  assign pop_cmd_o = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  // entry storage
  always_ff @(posedge clk_src_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_cmd_i;
    end
  end

  always_ff @(posedge clk_src_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers wrap at the last slot
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LastSlot) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastSlot) ? '0 : rd_ptr_q + 1'b1;
      end
      // push and pop on the same edge leave the count alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- logic/reg_bank.sv
module reg_bank #(
  parameter int NumRegs = 12
) (
  input  logic                                          clk_dst_i,
  input  logic                                          reset_i,
  // command from the crossing, one cycle strobe
  input  logic                                          cmd_valid_i,
  input  cfg_cmd_pkg::cfg_cmd_t                         cmd_i,
  // current register contents
  output logic [NumRegs-1:0][reg_map_pkg::RegWidth-1:0] regs_o,
  // one report per consumed command, one cycle after it
  output logic                                          upd_valid_o,
  output reg_map_pkg::reg_update_t                      upd_o
);
  import cfg_cmd_pkg::*;
  import reg_map_pkg::*;

  reg_data_t   regs_q [NumRegs];
  reg_data_t   cur_val;
  reg_data_t   new_val;
  logic        addr_ok;
  logic        upd_valid_q;
  reg_update_t upd_q;

  // address check and lookup of the current contents
  // out of range addresses read as 0 and are flagged
  always_comb begin
    addr_ok = 1'b0;
    cur_val = '0;
    for (int i = 0; i < NumRegs; i++) begin
      if (cmd_i.addr == AddrWidth'(i)) begin
        addr_ok = 1'b1;
        cur_val = regs_q[i];
      end
    end
  end

  // opcode decides the new contents
  always_comb begin
    case (cmd_i.op)
      op_write:      new_val = cmd_i.data;
      op_set_bits:   new_val = cur_val | cmd_i.data;
      op_clear_bits: new_val = cur_val & ~cmd_i.data;
      // unused encoding leaves the register as it is
      default:       new_val = cur_val;
    endcase
  end

  // register array, only the addressed entry moves
  always_ff @(posedge clk_dst_i) begin
    if (reset_i) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (cmd_valid_i) begin
      for (int i = 0; i < NumRegs; i++) begin
        if (cmd_i.addr == AddrWidth'(i)) begin
          regs_q[i] <= new_val;
        end
      end
    end
  end

  // report strobe
  always_ff @(posedge clk_dst_i) begin
    if (reset_i) begin
      upd_valid_q <= 1'b0;
    end else begin
      upd_valid_q <= cmd_valid_i;
    end
  end

  // report payload, captured with the command
  always_ff @(posedge clk_dst_i) begin
    if (cmd_valid_i) begin
      upd_q.addr     <= cmd_i.addr;
      upd_q.value    <= addr_ok ? new_val : '0;
      upd_q.bad_addr <= ~addr_ok;
    end
  end

  // flatten the array onto the packed output
  always_comb begin
    for (int i = 0; i < NumRegs; i++) begin
      regs_o[i] = regs_q[i];
    end
  end

  assign upd_valid_o = upd_valid_q;
  assign upd_o       = upd_q;

endmodule

//--- logic/reg_map_pkg.sv
package reg_map_pkg;

  // each control register is this wide
  localparam int RegWidth = 16;

  // register address width
  // 16 addresses are reachable, NumRegs of them are implemented
  localparam int AddrWidth = 4;

  typedef logic [RegWidth-1:0]  reg_data_t;
  typedef logic [AddrWidth-1:0] reg_addr_t;

  // report for one consumed command, 21 bits with the default widths
  typedef struct packed {
    // target address as received
    reg_addr_t addr;
    // register contents after the update, 0 for a bad address
    reg_data_t value;
    // address was at or above the number of implemented registers
    logic      bad_addr;
  } reg_update_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# build and run the cfg bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f compile.f \
  --top-module cfg_bridge_tb \
  -o cfg_bridge_sim

# the simulation may exit non-zero on failure, the log decides
./obj_dir/cfg_bridge_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

//--- sim/cfg_bridge_tb.sv
module cfg_bridge_tb;
  import cfg_cmd_pkg::*;
  import reg_map_pkg::*;

  localparam int QueueDepth   = 4;
  localparam int NumRegs      = 12;
  // source cycles of random traffic before and after the burst
  localparam int NumRandom    = 150;
  // extra source cycles with valid held high once the queue is full
  localparam int BurstLen     = 16;
  localparam int FullTimeout  = 40;
  localparam int HoldTimeout  = 200;
  localparam int DrainTimeout = 400;

  logic                              clk_src_i;
  logic                              clk_dst_i;
  logic                              reset_i;
  logic                              cmd_valid_i;
  cfg_cmd_t                          cmd_i;
  logic                              cmd_ready_o;
  logic [NumRegs-1:0][RegWidth-1:0]  regs_o;
  logic                              upd_valid_o;
  reg_update_t                       upd_o;

  int        seed;
  // reference copy of the register bank
  reg_data_t model_q [NumRegs];
  // accepted commands waiting for their report in order of acceptance
  cfg_cmd_t  exp_q [$];
  // driven command not yet taken by the bridge
  logic      pending;

  cfg_bridge_top #(
    .QueueDepth (QueueDepth),
    .NumRegs    (NumRegs)
  ) dut0 (
    .clk_src_i   (clk_src_i),
    .clk_dst_i   (clk_dst_i),
    .reset_i     (reset_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cmd_ready_o (cmd_ready_o),
    .regs_o      (regs_o),
    .upd_valid_o (upd_valid_o),
    .upd_o       (upd_o)
  );

  // destination clock with period 40
  initial begin
    clk_dst_i = 1'b0;
    forever #20 clk_dst_i = ~clk_dst_i;
  end

  // source clock with period 28 so the phases drift
  initial begin
    clk_src_i = 1'b0;
    forever #14 clk_src_i = ~clk_src_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_update(input reg_update_t exp, input reg_update_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERR upd_o expected %h got %h", exp, act));
    end
  endtask

  task automatic check_reg(input int idx, input reg_data_t exp, input reg_data_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERR regs_o[%0d] expected %h got %h", idx, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s expected %h got %h", name, exp, act));
    end
  endtask

  // random opcode and data with addresses over the full 4-bit range
  function automatic cfg_cmd_t random_cmd();
    cfg_cmd_t    c;
    logic [31:0] bits;
    bits   = $random(seed);
    c.op   = cfg_op_e'(2'(bits[7:0] % 8'd3));
    c.addr = bits[8 +: AddrWidth];
    c.data = bits[16 +: RegWidth];
    return c;
  endfunction

  // write replaces the register, set ors the data in and clear removes the data bits
  // out of range touches nothing and reports value 0
  task automatic apply_model(input cfg_cmd_t c, output reg_update_t exp);
    exp.addr = c.addr;
    if (int'(c.addr) < NumRegs) begin
      case (c.op)
        op_write:      model_q[c.addr] = c.data;
        op_set_bits:   model_q[c.addr] = model_q[c.addr] | c.data;
        op_clear_bits: model_q[c.addr] = model_q[c.addr] & ~c.data;
        default:       model_q[c.addr] = model_q[c.addr];
      endcase
      exp.value    = model_q[c.addr];
      exp.bad_addr = 1'b0;
    end else begin
      exp.value    = '0;
      exp.bad_addr = 1'b1;
    end
  endtask

  // one source cycle of stimulus on the falling edge
  // cmd_ready_o only moves on the rising edge so its value now decides the next accept
  task automatic src_step(input logic force_valid);
    logic [31:0] bits;
    @(negedge clk_src_i);
    if (!pending) begin
      bits        = $random(seed);
      cmd_valid_i = force_valid | (bits[1:0] != 2'd0);
      cmd_i       = random_cmd();
    end
    // queue entries never outnumber the commands still waiting for a report
    // so with fewer than QueueDepth of those the queue cannot be full
    if (exp_q.size() < QueueDepth) begin
      check_flag("cmd_ready_o", 1'b1, cmd_ready_o);
    end
    if (cmd_valid_i && cmd_ready_o) begin
      exp_q.push_back(cmd_i);
      pending = 1'b0;
    end else begin
      // a refused command is held until the bridge takes it
      pending = cmd_valid_i;
    end
  endtask

  // keep valid high until back-pressure shows up
  task automatic fill_queue();
    int i;
    i = 0;
    while (cmd_ready_o && i < FullTimeout) begin
      src_step(1'b1);
      i++;
    end
    if (cmd_ready_o) begin
      abort_run("burst never filled the queue, cmd_ready_o stayed high");
    end
  endtask

  // let a held command go through and then drop valid
  task automatic stop_stimulus();
    int i;
    i = 0;
    while (pending && i < HoldTimeout) begin
      src_step(1'b1);
      i++;
    end
    if (pending) begin
      abort_run("held command was never accepted by the bridge");
    end else begin
      @(negedge clk_src_i);
      cmd_valid_i = 1'b0;
    end
  endtask

  // every accepted command has to come back as a report
  task automatic wait_drained();
    int i;
    i = 0;
    while (exp_q.size() != 0 && i < DrainTimeout) begin
      @(negedge clk_dst_i);
      i++;
    end
    if (exp_q.size() != 0) begin
      abort_run($sformatf("timeout, %0d accepted commands never reported", exp_q.size()));
    end
  endtask

  // reports are sampled half a destination cycle after they are registered
  initial begin : report_monitor
    cfg_cmd_t    c;
    reg_update_t exp;
    forever begin
      @(negedge clk_dst_i);
      if (!reset_i && upd_valid_o) begin
        if (exp_q.size() == 0) begin
          abort_run("report seen with no accepted command outstanding");
        end else begin
          c = exp_q.pop_front();
          apply_model(c, exp);
          check_update(exp, upd_o);
          // whole bank against the model including bad addresses
          for (int i = 0; i < NumRegs; i++) begin
            check_reg(i, model_q[i], regs_o[i]);
          end
        end
      end
    end
  end

  initial begin : main_seq
    seed        = 80;
    pending     = 1'b0;
    reset_i     = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    for (int i = 0; i < NumRegs; i++) begin
      model_q[i] = '0;
    end

    // release on a destination falling edge away from both rising edges
    repeat (3) @(posedge clk_dst_i);
    @(negedge clk_dst_i);
    reset_i = 1'b0;

    // state right after reset
    check_flag("cmd_ready_o", 1'b1, cmd_ready_o);
    for (int i = 0; i < NumRegs; i++) begin
      check_reg(i, '0, regs_o[i]);
    end
    repeat (5) begin
      @(negedge clk_dst_i);
      check_flag("upd_valid_o", 1'b0, upd_valid_o);
    end

    // random traffic with gaps
    for (int i = 0; i < NumRandom; i++) begin
      src_step(1'b0);
    end

    // burst until full and keep pushing against back-pressure
    fill_queue();
    for (int i = 0; i < BurstLen; i++) begin
      src_step(1'b1);
    end

    for (int i = 0; i < NumRandom; i++) begin
      src_step(1'b0);
    end

    stop_stimulus();
    wait_drained();
    // a late extra report in this quiet window would trip the monitor
    repeat (20) @(negedge clk_dst_i);

    $display("All tests passed");
    $finish;
  end

endmodule
